//--- compile.f
+incdir+logic
logic/fan_in_pkg.sv
logic/axis_if.sv
logic/axis_chan_fifo.sv
logic/prio_encoder.sv
logic/axis_fan_in.sv
logic/fan_in_top.sv
tb/tb_fan_in.sv

//--- run_sim.sh
#!/bin/sh
# build the fan-in testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_fan_in \
  -o tb_fan_in > build.log 2>&1 \
  && ./obj_dir/tb_fan_in > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1

//--- tb/tb_fan_in.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the stream fan-in
// directed and LFSR driven stimulus checked by assertions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fan_in_config.svh"

module tb_fan_in
  import fan_in_pkg::*;
();

  localparam int NUM_CHAN       = `FAN_IN_NUM_CHAN;
  localparam int DW             = `FAN_IN_DATA_WIDTH;
  localparam int CB             = `FAN_IN_CHAN_BITS;
  localparam int DEPTH          = `FAN_IN_FIFO_DEPTH;
  localparam int SEQ_W          = 16;
  localparam int RAND_BEATS     = 400;
  localparam int TOTAL_BEATS    = NUM_CHAN * RAND_BEATS + NUM_CHAN + DEPTH + 3;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_BEATS * NUM_CHAN + 200;

  // DUT ports
  logic                   m_axis_clk;
  logic                   m_axis_rst;
  logic [NUM_CHAN-1:0]    s_tvalid;
  logic [NUM_CHAN-1:0]    s_tready;
  logic [NUM_CHAN*DW-1:0] s_tdata;
  logic [NUM_CHAN-1:0]    s_tlast;
  logic                   m_tvalid;
  logic                   m_tready;
  logic [DW-1:0]          m_tdata;
  logic                   m_tlast;
  chan_idx_t              m_tuser;

  // stimulus state, owned by the initial block
  logic [15:0]         lfsr;
  logic [SEQ_W-1:0]    drv_seq [NUM_CHAN];
  int                  quota [NUM_CHAN];
  int                  pkt_left [NUM_CHAN];
  logic [1023:0]       sent_last [NUM_CHAN];
  logic                rand_mode;
  int                  ready_mode;
  logic                prio_check;
  logic                full_check;

  // monitor state, updated on the rising edge
  logic [NUM_CHAN-1:0] acc;
  logic [SEQ_W-1:0]    exp_seq [NUM_CHAN];
  int                  beats_in;
  int                  beats_out;
  logic                in_pkt;
  chan_idx_t           pkt_chan;
  chan_idx_t           prio_next;
  int                  full_accept;
  int                  cycles = 0;
  int                  errors = 0;

  // fields of the output beat
  chan_idx_t           data_chan;
  logic [SEQ_W-1:0]    data_seq;
  logic [SEQ_W-1:0]    exp_seq_cur;
  logic                exp_last_cur;

  fan_in_top i_dut (
    .m_axis_clk (m_axis_clk),
    .m_axis_rst (m_axis_rst),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .s_tlast    (s_tlast),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tlast    (m_tlast),
    .m_tuser    (m_tuser)
  );

  always #2 m_axis_clk = ~m_axis_clk;

  assign data_chan    = m_tdata[DW-1 -: CB];
  assign data_seq     = m_tdata[SEQ_W-1:0];
  assign exp_seq_cur  = exp_seq[m_tuser];
  assign exp_last_cur = sent_last[m_tuser][data_seq[9:0]];

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(take_bit());
    end
    return v;
  endfunction

  // channel number on top, sequence number at the bottom
  function automatic logic [DW-1:0] make_word(input int ch, input logic [SEQ_W-1:0] seq);
    return {chan_idx_t'(ch), {(DW - CB - SEQ_W){1'b0}}, seq};
  endfunction

  function automatic logic stream_busy();
    logic busy;
    busy = m_tvalid || (beats_out < beats_in);
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      busy = busy || s_tvalid[ch] || (quota[ch] > 0) || (pkt_left[ch] > 0);
    end
    return busy;
  endfunction

  // runs on the falling edge, a held beat stays until it is taken
  task automatic drive_inputs();
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      if (s_tvalid[ch] && acc[ch]) begin
        drv_seq[ch]  = drv_seq[ch] + 16'd1;
        pkt_left[ch] = pkt_left[ch] - 1;
        quota[ch]    = quota[ch] - 1;
        s_tvalid[ch] = 1'b0;
      end
      if (!s_tvalid[ch] && (quota[ch] > 0 || pkt_left[ch] > 0)) begin
        if (!rand_mode || take_bits(2) != 0) begin
          if (pkt_left[ch] == 0) begin
            pkt_left[ch] = rand_mode ? take_bits(2) + 1 : 1;
          end
          s_tvalid[ch]               = 1'b1;
          s_tdata[ch*DW +: DW]       = make_word(ch, drv_seq[ch]);
          s_tlast[ch]                = (pkt_left[ch] == 1);
          sent_last[ch][drv_seq[ch][9:0]] = s_tlast[ch];
        end
      end
    end
    if (ready_mode == 2) begin
      m_tready = (take_bits(2) != 0);
    end else begin
      m_tready = (ready_mode == 1);
    end
  endtask

  task automatic step();
    @(negedge m_axis_clk);
    drive_inputs();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge m_axis_clk) begin
    if (m_axis_rst) begin
      acc         <= '0;
      beats_in    <= 0;
      beats_out   <= 0;
      in_pkt      <= 1'b0;
      pkt_chan    <= '0;
      prio_next   <= '0;
      full_accept <= 0;
      for (int ch = 0; ch < NUM_CHAN; ch++) begin
        exp_seq[ch] <= '0;
      end
    end else begin
      acc      <= s_tvalid & s_tready;
      beats_in <= beats_in + $countones(s_tvalid & s_tready);
      if (!full_check) begin
        full_accept <= 0;
      end else if (s_tvalid[0] && s_tready[0]) begin
        full_accept <= full_accept + 1;
      end
      if (m_tvalid && m_tready) begin
        beats_out         <= beats_out + 1;
        exp_seq[m_tuser]  <= exp_seq[m_tuser] + 16'd1;
        in_pkt            <= !m_tlast;
        pkt_chan          <= m_tuser;
        prio_next         <= prio_next + chan_idx_t'(1);
      end
    end
  end

  always @(posedge m_axis_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without reaching the end of the test", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_state: assert property (
    @(posedge m_axis_clk) $fell(m_axis_rst) |-> !m_tvalid && (s_tready == '1)
  ) else begin
    errors++;
    $display("%0t output valid high or input ready low right after reset", $time);
  end

  a_user_match: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    m_tvalid |-> m_tuser == data_chan
  ) else begin
    errors++;
    $display("[ERROR] %0t m_tuser expected %0d got %0d",
             $time, $sampled(data_chan), $sampled(m_tuser));
  end

  // per channel order with nothing missing
  a_seq_order: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    m_tvalid && m_tready |-> data_seq == exp_seq_cur
  ) else begin
    errors++;
    $display("[ERROR] %0t m_tdata[15:0] expected %0d got %0d",
             $time, $sampled(exp_seq_cur), $sampled(data_seq));
  end

  a_last_match: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    m_tvalid && m_tready |-> m_tlast == exp_last_cur
  ) else begin
    errors++;
    $display("[ERROR] %0t m_tlast expected %0b got %0b",
             $time, $sampled(exp_last_cur), $sampled(m_tlast));
  end

  a_packet_atomic: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    m_tvalid && m_tready && in_pkt |-> m_tuser == pkt_chan
  ) else begin
    errors++;
    $display("[ERROR] %0t m_tuser expected %0d got %0d",
             $time, $sampled(pkt_chan), $sampled(m_tuser));
  end

  a_prio_order: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    prio_check && m_tvalid && m_tready |-> m_tuser == prio_next
  ) else begin
    errors++;
    $display("[ERROR] %0t m_tuser expected %0d got %0d",
             $time, $sampled(prio_next), $sampled(m_tuser));
  end

  a_hold: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    m_tvalid && !m_tready |=>
      m_tvalid && $stable(m_tdata) && $stable(m_tlast) && $stable(m_tuser)
  ) else begin
    errors++;
    $display("%0t output beat changed or dropped while the sink stalled", $time);
  end

  // fifo depth plus the output register
  a_full_level: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    full_check && !s_tready[0] |-> full_accept == DEPTH + 1
  ) else begin
    errors++;
    $display("[ERROR] %0t s_tready[0] fell after accepted beats expected %0d got %0d",
             $time, DEPTH + 1, $sampled(full_accept));
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    m_axis_clk = 1'b0;
    m_axis_rst = 1'b1;
    s_tvalid   = '0;
    s_tdata    = '0;
    s_tlast    = '0;
    m_tready   = 1'b0;
    lfsr       = 16'd75;
    rand_mode  = 1'b0;
    ready_mode = 0;
    prio_check = 1'b0;
    full_check = 1'b0;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      drv_seq[ch]   = '0;
      quota[ch]     = 0;
      pkt_left[ch]  = 0;
      sent_last[ch] = '0;
    end
    repeat (3) @(posedge m_axis_clk);
    @(negedge m_axis_clk);
    m_axis_rst = 1'b0;

    // every channel offers one beat in the same cycle, sink stalled
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      quota[ch] = 1;
    end
    while (beats_in < NUM_CHAN) step();
    repeat (4) step();
    prio_check = 1'b1;
    ready_mode = 1;
    while (beats_out < NUM_CHAN) step();
    prio_check = 1'b0;
    while (stream_busy()) step();

    // fill channel 0 against a stalled sink
    full_check = 1'b1;
    ready_mode = 0;
    quota[0]   = DEPTH + 3;
    while (s_tready[0]) step();
    repeat (2) step();
    full_check = 1'b0;
    ready_mode = 1;
    while (stream_busy()) step();

    // random traffic with random back-pressure
    rand_mode  = 1'b1;
    ready_mode = 2;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      quota[ch] = RAND_BEATS;
    end
    while (stream_busy()) step();
    ready_mode = 1;
    repeat (4) step();

    a_complete: assert (beats_out == beats_in) else begin
      errors++;
      $display("[ERROR] %0t beats_out expected %0d got %0d", $time, beats_in, beats_out);
    end
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      assert (exp_seq[ch] == drv_seq[ch]) else begin
        errors++;
        $display("[ERROR] %0t beats out of channel %0d expected %0d got %0d",
                 $time, ch, drv_seq[ch], exp_seq[ch]);
      end
    end

    $display("errors: %0d  beats in: %0d  beats out: %0d", errors, beats_in, beats_out);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- logic/fan_in_top.sv
////////////////////////////////////////////////////////////////////////////
// fan-in top level
// flat stream ports mapped onto interfaces around the core
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fan_in_config.svh"

module fan_in_top
  import fan_in_pkg::*;
(
  input  logic                                            m_axis_clk,
  input  logic                                            m_axis_rst,

  // input streams, channel 0 in the low bits
  input  logic [`FAN_IN_NUM_CHAN-1:0]                     s_tvalid,
  output logic [`FAN_IN_NUM_CHAN-1:0]                     s_tready,
  input  logic [`FAN_IN_NUM_CHAN*`FAN_IN_DATA_WIDTH-1:0]  s_tdata,
  input  logic [`FAN_IN_NUM_CHAN-1:0]                     s_tlast,

  // merged output stream
  output logic                                            m_tvalid,
  input  logic                                            m_tready,
  output logic [`FAN_IN_DATA_WIDTH-1:0]                   m_tdata,
  output logic                                            m_tlast,
  output chan_idx_t                                       m_tuser
);

  localparam int NUM_CHAN = `FAN_IN_NUM_CHAN;
  localparam int DW       = `FAN_IN_DATA_WIDTH;

  axis_if s_chan [NUM_CHAN] ();
  axis_if m_out ();

  // slice the flat input buses per channel
  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_in
    assign s_chan[i].valid = s_tvalid[i];
    assign s_chan[i].data  = '{data: s_tdata[i*DW +: DW], last: s_tlast[i]};
    assign s_tready[i]     = s_chan[i].ready;
  end

  axis_fan_in i_fan_in (
    .m_axis_clk (m_axis_clk),
    .m_axis_rst (m_axis_rst),
    .s_chan     (s_chan),
    .m_out      (m_out)
  );

  // output side
  assign m_out.ready = m_tready;
  assign m_tvalid    = m_out.valid;
  assign m_tdata     = m_out.data.data;
  assign m_tlast     = m_out.data.last;
  assign m_tuser     = m_out.user;

endmodule

//--- logic/axis_fan_in.sv
////////////////////////////////////////////////////////////////////////////
// stream fan-in core
// channel buffers, packet-locked selection and output register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fan_in_config.svh"

module axis_fan_in
  import fan_in_pkg::*;
(
  input logic    m_axis_clk,
  input logic    m_axis_rst,
  axis_if.sink   s_chan [`FAN_IN_NUM_CHAN],
  axis_if.source m_out
);

  localparam int NUM_CHAN = `FAN_IN_NUM_CHAN;

  // read side of the channel buffers
  axis_if fifo_rd [NUM_CHAN] ();

  // flattened head view
  logic [NUM_CHAN-1:0] head_valid;
  beat_t               head_beat [NUM_CHAN];
  logic [NUM_CHAN-1:0] rd_strobe;

  // encoder result
  chan_idx_t           prio_idx;
  logic                prio_any;

  // packet lock
  logic                lock_q;
  chan_idx_t           lock_chan_q;

  // selection
  chan_idx_t           sel_chan;
  logic                sel_valid;
  beat_t               sel_beat;
  logic                out_load;
  logic                take;

  // output register
  logic                out_valid_q;
  beat_t               out_beat_q;
  chan_idx_t           out_user_q;

  ////////////////////////////////////////////////////////////////////////////
  // channel buffers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    axis_chan_fifo #(
      .WIDTH ($bits(beat_t)),
      .DEPTH (`FAN_IN_FIFO_DEPTH)
    ) i_fifo (
      .m_axis_clk (m_axis_clk),
      .m_axis_rst (m_axis_rst),
      .wr         (s_chan[i]),
      .rd         (fifo_rd[i])
    );

    assign head_valid[i]    = fifo_rd[i].valid;
    assign head_beat[i]     = fifo_rd[i].data;
    assign fifo_rd[i].ready = rd_strobe[i];
  end

  ////////////////////////////////////////////////////////////////////////////
  // channel selection
  ////////////////////////////////////////////////////////////////////////////

  prio_encoder #(
    .WIDTH (NUM_CHAN)
  ) i_prio (
    .req (head_valid),
    .idx (prio_idx),
    .any (prio_any)
  );

  // locked channel wins even while its head is empty
  assign sel_chan  = lock_q ? lock_chan_q : prio_idx;
  assign sel_valid = lock_q ? head_valid[lock_chan_q] : prio_any;
  assign sel_beat  = head_beat[sel_chan];

  // output register free or draining this cycle
  assign out_load  = !out_valid_q || m_out.ready;
  assign take      = out_load && sel_valid;

  always_comb begin
    rd_strobe = '0;
    if (take) begin
      rd_strobe[sel_chan] = 1'b1;
    end
  end

  // hold the channel until its last beat goes through
  always_ff @(posedge m_axis_clk) begin
    if (m_axis_rst) begin
      lock_q      <= 1'b0;
      lock_chan_q <= '0;
    end else if (take) begin
      lock_q      <= !sel_beat.last;
      lock_chan_q <= sel_chan;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (m_axis_rst) begin
      out_valid_q <= 1'b0;
    end else if (out_load) begin
      out_valid_q <= sel_valid;
    end
  end

  always_ff @(posedge m_axis_clk) begin
    if (take) begin
      out_beat_q <= sel_beat;
      out_user_q <= sel_chan;
    end
  end

  assign m_out.valid = out_valid_q;
  assign m_out.data  = out_beat_q;
  assign m_out.user  = out_user_q;

  // beat held steady while the sink stalls
  a_out_stable: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    m_out.valid && !m_out.ready |=>
      m_out.valid && $stable(m_out.data) && $stable(m_out.user)
  ) else $error("output beat changed under back-pressure");

  // only one buffer handshakes per cycle
  a_one_read: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    $onehot0(rd_strobe & head_valid)
  ) else $error("more than one channel read in a cycle");

endmodule

//--- logic/prio_encoder.sv
////////////////////////////////////////////////////////////////////////////
// lowest-index-first priority encoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module prio_encoder
  import fan_in_pkg::*;
#(
  parameter int WIDTH = 4
) (
  input  logic [WIDTH-1:0] req,
  output chan_idx_t        idx,
  output logic             any
);

  // scan downward so the lowest set bit is written last
  always_comb begin
    idx = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (req[i]) begin
        idx = chan_idx_t'(i);
      end
    end
  end

  assign any = |req;

endmodule

//--- logic/axis_chan_fifo.sv
////////////////////////////////////////////////////////////////////////////
// per-channel synchronous stream FIFO
// circular buffer behind a registered head beat
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module axis_chan_fifo
  import fan_in_pkg::*;
#(
  parameter int WIDTH = 33,
  parameter int DEPTH = 8
) (
  input logic    m_axis_clk,
  input logic    m_axis_rst,
  axis_if.sink   wr,
  axis_if.source rd
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // storage
  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // occupancy, head register included
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] mem_cnt;
  logic             full;

  // head register
  logic [WIDTH-1:0] head_q;
  logic             head_valid_q;

  logic             wr_fire;
  logic             rd_fire;
  logic             head_load;

  assign full      = (count == CNT_W'(DEPTH));
  assign wr_fire   = wr.valid && !full;
  assign rd_fire   = head_valid_q && rd.ready;

  // entries still sitting in the ring
  assign mem_cnt   = count - CNT_W'(head_valid_q);

  // refill head when it empties or is taken this cycle
  assign head_load = (!head_valid_q || rd_fire) && (mem_cnt != '0);

  assign wr.ready  = !full;
  assign rd.valid  = head_valid_q;
  assign rd.data   = beat_t'(head_q);

  always_ff @(posedge m_axis_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr.data;
    end
    if (head_load) begin
      head_q <= mem[rd_ptr];
    end
  end

  always_ff @(posedge m_axis_clk) begin
    if (m_axis_rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      head_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (head_load) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_fire) - CNT_W'(rd_fire);
      if (head_load) begin
        head_valid_q <= 1'b1;
      end else if (rd_fire) begin
        head_valid_q <= 1'b0;
      end
    end
  end

  // occupancy bound over any mix of pushes and pops
  a_count_bound: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    count <= CNT_W'(DEPTH)
  ) else $error("channel fifo count above depth");

endmodule

//--- logic/axis_if.sv
////////////////////////////////////////////////////////////////////////////
// valid/ready stream interface with source and sink views
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fan_in_config.svh"

interface axis_if
  import fan_in_pkg::*;
();

  // handshake
  logic      valid;
  logic      ready;

  // beat and origin channel
  // user only carries meaning on the merged output
  beat_t     data;
  chan_idx_t user;

  modport source (
    output valid,
    output data,
    output user,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  user,
    output ready
  );

endinterface

//--- logic/fan_in_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types of the fan-in
// channel index and the beat word stored in the buffers
////////////////////////////////////////////////////////////////////////////

`include "fan_in_config.svh"

package fan_in_pkg;

  // binary channel number, also what goes out on user
  typedef logic [`FAN_IN_CHAN_BITS-1:0] chan_idx_t;

  // one stream beat
  // payload plus end of packet marker
  typedef struct packed {
    logic [`FAN_IN_DATA_WIDTH-1:0] data;
    logic                          last;
  } beat_t;

endpackage

//--- logic/fan_in_config.svh
////////////////////////////////////////////////////////////////////////////
// build-time sizes of the stream fan-in
////////////////////////////////////////////////////////////////////////////

`ifndef FAN_IN_CONFIG_SVH
`define FAN_IN_CONFIG_SVH

// number of input streams
`define FAN_IN_NUM_CHAN 4

// data bits carried by one beat
`define FAN_IN_DATA_WIDTH 32

// entries per channel buffer, power of two and at least two
`define FAN_IN_FIFO_DEPTH 8

// bits needed for a channel number, never less than one
`define FAN_IN_CHAN_BITS \
  (($clog2(`FAN_IN_NUM_CHAN) > 0) ? $clog2(`FAN_IN_NUM_CHAN) : 1)

`endif
